// File: design/alu_branch.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu_branch (
    input  rv_isa_pkg::decoded_t dec_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  logic [`XLEN-1:0]     rs1_val_i,
    input  logic [`XLEN-1:0]     rs2_val_i,
    output logic [`XLEN-1:0]     result_o,
    output logic                 take_branch_o,
    output logic [`XLEN-1:0]     target_o
);

    import rv_isa_pkg::*;

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic             cond;

    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_val_i;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_out = rs1_val_i + op_b;  // also load/store address
            ALU_SUB:    alu_out = rs1_val_i - op_b;
            ALU_XOR:    alu_out = rs1_val_i ^ op_b;
            ALU_OR:     alu_out = rs1_val_i | op_b;
            ALU_AND:    alu_out = rs1_val_i & op_b;
            ALU_SLL:    alu_out = rs1_val_i << op_b[4:0];
            ALU_SRL:    alu_out = rs1_val_i >> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // link value for jumps
    assign result_o = (dec_i.is_jal || dec_i.is_jalr) ? pc_i + `PC_STEP : alu_out;

    // signed compares on the register values
    always_comb begin
        case (dec_i.br_cond)
            BEQ:     cond = (rs1_val_i == rs2_val_i);
            BNE:     cond = (rs1_val_i != rs2_val_i);
            BLT:     cond = ($signed(rs1_val_i) < $signed(rs2_val_i));
            BGE:     cond = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            default: cond = 1'b0;
        endcase
    end

    assign take_branch_o = dec_i.is_branch & cond;

    always_comb begin
        if (dec_i.is_jalr) begin
            target_o = (rs1_val_i + dec_i.imm) & ~`XLEN'(1);  // bit 0 cleared
        end else begin
            target_o = pc_i + dec_i.imm;
        end
    end

endmodule

// File: design/bus_port.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module bus_port (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_bus_pkg::fsm_state_e  state_i,
    input  logic [`XLEN-1:0]         pc_i,
    input  rv_isa_pkg::decoded_t     dec_i,
    input  logic [`XLEN-1:0]         result_i,
    input  logic [`XLEN-1:0]         rs2_val_i,
    input  logic [`XLEN-1:0]         mem_rdata_i,
    input  logic                     bus_full_i,
    output logic [`XLEN-1:0]         instr_o,
    output logic                     fetch_done_o,
    output logic                     mem_done_o,
    output cpu_bus_pkg::mem_req_t    mem_o,
    output cpu_bus_pkg::wb_t         wb_o
);

    import cpu_bus_pkg::*;

    // completion is the first edge with the bus not full
    assign fetch_done_o = (state_i == ST_FETCH) && !bus_full_i;
    assign mem_done_o   = (state_i == ST_MEM) && !bus_full_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_o <= '0;
        end else if (fetch_done_o) begin
            instr_o <= mem_rdata_i;
        end
    end

    always_comb begin
        mem_o.rd    = (state_i == ST_FETCH) || (state_i == ST_MEM && dec_i.is_load);
        mem_o.wr    = (state_i == ST_MEM) && dec_i.is_store;
        mem_o.addr  = (state_i == ST_FETCH) ? pc_i : {result_i[`XLEN-1:2], 2'b00};
        mem_o.wdata = rs2_val_i;
    end

    // alu and jump results write in exec, loads when the read completes
    always_comb begin
        wb_o.rd   = dec_i.rd;
        wb_o.data = dec_i.is_load ? mem_rdata_i : result_i;
        wb_o.en   = dec_i.reg_we &&
                    (((state_i == ST_EXEC) && !dec_i.is_load) ||
                     (mem_done_o && dec_i.is_load));
    end

endmodule

// File: design/cpu_bus_pkg.sv
`include "cpu_config.svh"

package cpu_bus_pkg;

    // instruction sequencer phases
    typedef enum logic [1:0] {
        ST_INIT,
        ST_FETCH,
        ST_EXEC,
        ST_MEM
    } fsm_state_e;

    // request on the shared memory bus
    typedef struct packed {
        logic             rd;
        logic             wr;
        logic [`XLEN-1:0] addr;   // word aligned
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    // register writeback, also visible at the top
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define XLEN 32

// integer register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// program counter
`define RESET_PC 32'h0000_0000
`define PC_STEP 4

`endif

// File: design/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       mem_rdata_i,
    input  logic                   bus_full_i,
    output cpu_bus_pkg::mem_req_t  mem_o,
    output cpu_bus_pkg::wb_t       wb_o
);

    import rv_isa_pkg::*;
    import cpu_bus_pkg::*;

    fsm_state_e       state;
    decoded_t         dec;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] rs1_val, rs2_val;
    logic             take_branch;
    logic             fetch_done, mem_done;

    cycle_fsm cycle_fsm_inst (
        .clk(clk), .rst(rst), .dec_i(dec), .fetch_done_i(fetch_done),
        .mem_done_i(mem_done), .state_o(state)
    );

    program_counter program_counter_inst (
        .clk(clk), .rst(rst), .state_i(state), .dec_i(dec),
        .take_branch_i(take_branch), .target_i(target), .pc_o(pc)
    );

    instr_decoder instr_decoder_inst (.instr_i(instr), .dec_o(dec));

    alu_branch alu_branch_inst (
        .dec_i(dec), .pc_i(pc), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .result_o(result), .take_branch_o(take_branch), .target_o(target)
    );

    // writeback port feeds the register file directly
    register_file register_file_inst (
        .clk(clk), .rst(rst), .rs1_i(dec.rs1), .rs2_i(dec.rs2), .wb_i(wb_o),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

    bus_port bus_port_inst (
        .clk(clk), .rst(rst), .state_i(state), .pc_i(pc), .dec_i(dec),
        .result_i(result), .rs2_val_i(rs2_val), .mem_rdata_i(mem_rdata_i),
        .bus_full_i(bus_full_i), .instr_o(instr), .fetch_done_o(fetch_done),
        .mem_done_o(mem_done), .mem_o(mem_o), .wb_o(wb_o)
    );

endmodule

// File: design/cycle_fsm.sv
`timescale 1ns/1ps

module cycle_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  rv_isa_pkg::decoded_t     dec_i,
    input  logic                     fetch_done_i,
    input  logic                     mem_done_i,
    output cpu_bus_pkg::fsm_state_e  state_o
);

    import cpu_bus_pkg::*;

    fsm_state_e state_next;
    logic       needs_mem;

    assign needs_mem = dec_i.is_load | dec_i.is_store;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_o <= ST_INIT;
        end else begin
            state_o <= state_next;
        end
    end

    // each phase waits on its own bus completion
    always_comb begin
        state_next = state_o;
        case (state_o)
            ST_INIT: begin
                state_next = ST_FETCH;
            end
            ST_FETCH: begin
                if (fetch_done_i) begin
                    state_next = ST_EXEC;
                end
            end
            ST_EXEC: begin
                // only loads and stores touch the bus again
                if (needs_mem) begin
                    state_next = ST_MEM;
                end else begin
                    state_next = ST_FETCH;
                end
            end
            ST_MEM: begin
                if (mem_done_i) begin
                    state_next = ST_FETCH;
                end
            end
            default: begin
                state_next = ST_INIT;
            end
        endcase
    end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]     instr_i,
    output rv_isa_pkg::decoded_t dec_o
);

    import rv_isa_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    alu_op_e          grp_op;     // alu op from funct3
    logic             grp_ok;     // funct3 is in the supported set
    logic             writes_rd;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        grp_ok = 1'b1;
        case (funct3)
            F3_ADD:  grp_op = ALU_ADD;
            F3_SLL:  grp_op = ALU_SLL;
            F3_XOR:  grp_op = ALU_XOR;
            F3_SRL:  grp_op = ALU_SRL;
            F3_OR:   grp_op = ALU_OR;
            F3_AND:  grp_op = ALU_AND;
            default: begin
                grp_op = ALU_ADD;
                grp_ok = 1'b0;    // slt/sltu not kept
            end
        endcase
    end

    always_comb begin
        dec_o         = '0;   // unknown opcode ends up a no-op
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.rd      = instr_i[11:7];
        dec_o.alu_op  = ALU_ADD;
        dec_o.br_cond = br_cond_e'(funct3);
        writes_rd     = 1'b0;
        case (opcode)
            OP_LUI: begin
                dec_o.imm = imm_u;
                dec_o.alu_op = ALU_PASS_B;
                dec_o.use_imm = 1'b1;
                writes_rd = 1'b1;
            end
            OP_JAL: begin
                dec_o.imm = imm_j;
                dec_o.is_jal = 1'b1;
                writes_rd = 1'b1;
            end
            OP_JALR: begin
                dec_o.imm = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.is_jalr = 1'b1;
                writes_rd = 1'b1;
            end
            OP_BRANCH: begin
                dec_o.imm = imm_b;
                dec_o.is_branch = (funct3 == BEQ) || (funct3 == BNE) ||
                                  (funct3 == BLT) || (funct3 == BGE);
            end
            OP_LOAD: begin
                dec_o.imm = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.is_load = 1'b1;
                writes_rd = 1'b1;
            end
            OP_STORE: begin
                dec_o.imm = imm_s;
                dec_o.use_imm = 1'b1;
                dec_o.is_store = 1'b1;
            end
            OP_IMM: begin
                dec_o.imm = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.alu_op = grp_op;
                writes_rd = grp_ok;
            end
            OP_REG: begin
                dec_o.alu_op = (funct3 == F3_ADD && funct7 == F7_SUB) ? ALU_SUB : grp_op;
                writes_rd = grp_ok;
            end
            default: ;
        endcase
        dec_o.reg_we = writes_rd && (dec_o.rd != '0);
    end

endmodule

// File: design/program_counter.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module program_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_bus_pkg::fsm_state_e  state_i,
    input  rv_isa_pkg::decoded_t     dec_i,
    input  logic                     take_branch_i,
    input  logic [`XLEN-1:0]         target_i,
    output logic [`XLEN-1:0]         pc_o
);

    import cpu_bus_pkg::*;

    logic             redirect;
    logic [`XLEN-1:0] pc_next;

    // take_branch_i is already qualified by is_branch
    assign redirect = take_branch_i | dec_i.is_jal | dec_i.is_jalr;

    always_comb begin
        if (redirect) begin
            pc_next = target_i;
        end else begin
            pc_next = pc_o + `PC_STEP;
        end
    end

    // one update per instruction, on the edge leaving exec
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o <= `RESET_PC;
        end else if (state_i == ST_EXEC) begin
            pc_o <= pc_next;
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  rs1_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_i,
    input  cpu_bus_pkg::wb_t        wb_i,
    output logic [`XLEN-1:0]        rs1_val_o,
    output logic [`XLEN-1:0]        rs2_val_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 is hardwired
    assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: design/rv_isa_pkg.sv
`include "cpu_config.svh"

package rv_isa_pkg;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui
    } alu_op_e;

    // branch funct3, signed compares only
    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001,
        BLT = 3'b100,
        BGE = 3'b101
    } br_cond_e;

    // funct3 / funct7 of the alu group
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;  // sign-extended
        alu_op_e                alu_op;
        logic                   use_imm;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_jalr;
        br_cond_e               br_cond;
        logic                   reg_we;  // false for rd == x0
    } decoded_t;

endpackage

// File: sim/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic                    bus_full_i,
    input cpu_bus_pkg::fsm_state_e state_i,
    input cpu_bus_pkg::mem_req_t   mem_i,
    input cpu_bus_pkg::wb_t        wb_i
);

    import cpu_bus_pkg::*;

    logic bus_active;
    int   fail_count;  // failed assertions so far

    assign bus_active = mem_i.rd || mem_i.wr;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_i.rd && mem_i.wr))
        else begin
            fail_count++;
            $error("bus rd and wr high together");
        end

    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        bus_active |-> (mem_i.addr[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("bus address not word aligned");
        end

    // a stalled request must not move
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (bus_active && bus_full_i) |=> $stable(mem_i))
        else begin
            fail_count++;
            $error("bus request changed during a stall");
        end

    // checked through reset too
    a_init_quiet: assert property (@(posedge clk)
        (state_i == ST_INIT) |-> (!bus_active && !wb_i.en))
        else begin
            fail_count++;
            $error("bus or writeback active in init");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb_i.en |-> (wb_i.rd != '0))
        else begin
            fail_count++;
            $error("writeback pulse for x0");
        end

    a_exec_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (state_i == ST_EXEC) |=> (state_i != ST_EXEC))
        else begin
            fail_count++;
            $error("exec phase longer than one cycle");
        end

endmodule

bind cpu_top cpu_asserts cpu_asserts_inst (
    .clk(clk), .rst(rst), .bus_full_i(bus_full_i), .state_i(state),
    .mem_i(mem_o), .wb_i(wb_o)
);

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;

    import cpu_bus_pkg::*;

    localparam int N_INSTR    = 2000;
    localparam int STALL_ALLOW = 3;  // stall cycles per instruction, generous for 1 in 4
    localparam int MAX_CYCLES = (3 + STALL_ALLOW) * N_INSTR + 200;

    // instruction kinds of the generated program
    localparam int K_LUI = 0, K_JAL = 1, K_JALR = 2, K_BR = 3;
    localparam int K_LOAD = 4, K_STORE = 5, K_IMM = 6, K_REG = 7;

    typedef struct packed {
        logic             wr;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
        logic [2:0]       cls;  // test number the event belongs to
    } acc_ev_t;

    typedef struct packed {
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic [2:0]       cls;
    } wb_ev_t;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] mem_rdata_i;
    logic             bus_full_i;
    mem_req_t         mem_o;
    wb_t              wb_o;

    logic [`XLEN-1:0] mem [512];
    int               p_kind [256];
    logic [4:0]       p_rd [256];
    logic [4:0]       p_rs1 [256];
    logic [4:0]       p_rs2 [256];
    logic [2:0]       p_f3 [256];
    logic             p_sub [256];
    logic [`XLEN-1:0] p_imm [256];

    acc_ev_t  exp_acc [$];
    wb_ev_t   exp_wb [$];
    acc_ev_t  acc_e;
    wb_ev_t   wb_e;
    mem_req_t held_req;
    logic     stalled, init_done, run_done;
    int       cycles, acc_idx, wb_idx, n_stall;
    int       err [1:5];

    cpu_top cpu_top_inst (
        .clk(clk), .rst(rst), .mem_rdata_i(mem_rdata_i), .bus_full_i(bus_full_i),
        .mem_o(mem_o), .wb_o(wb_o)
    );

    assign mem_rdata_i = mem[mem_o.addr[10:2]];  // answers within the cycle

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [`XLEN-1:0] encode(int i);
        logic [`XLEN-1:0] m;
        logic [6:0]       f7;
        m = p_imm[i];
        f7 = p_sub[i] ? 7'b0100000 : 7'b0000000;
        case (p_kind[i])
            K_LUI:   return {m[31:12], p_rd[i], 7'b0110111};
            K_JAL:   return {m[20], m[10:1], m[11], m[19:12], p_rd[i], 7'b1101111};
            K_JALR:  return {m[11:0], p_rs1[i], 3'b000, p_rd[i], 7'b1100111};
            K_BR:    return {m[12], m[10:5], p_rs2[i], p_rs1[i], p_f3[i], m[4:1], m[11],
                             7'b1100011};
            K_LOAD:  return {m[11:0], p_rs1[i], 3'b010, p_rd[i], 7'b0000011};
            K_STORE: return {m[11:5], p_rs2[i], p_rs1[i], 3'b010, m[4:0], 7'b0100011};
            K_IMM:   return {m[11:0], p_rs1[i], p_f3[i], p_rd[i], 7'b0010011};
            default: return {f7, p_rs2[i], p_rs1[i], p_f3[i], p_rd[i], 7'b0110011};
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(logic [2:0] f3, logic sub,
                                                 logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [`XLEN-1:0] a,
                                        logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    // random legal program in words 0..255, word 255 always jumps back
    task automatic gen_program();
        int alu_f3 [6] = '{0, 1, 4, 5, 6, 7};
        int delta;
        for (int i = 0; i < 256; i++) begin
            p_kind[i] = (i == 255) ? K_JAL : int'($urandom % 8);
            p_rd[i]   = 5'($urandom);
            p_rs1[i]  = 5'($urandom);
            p_rs2[i]  = 5'($urandom);
            p_f3[i]   = 3'(alu_f3[$urandom % 6]);
            p_sub[i]  = 1'b0;
            delta = int'($urandom_range(1, 8));  // target distance in words
            if (i + delta > 255 || (($urandom % 2) == 1 && i >= delta)) begin
                delta = -delta;
            end
            case (p_kind[i])
                K_LUI: p_imm[i] = $urandom & 32'hffff_f000;
                K_JAL: p_imm[i] = delta * 4;
                K_JALR: begin
                    p_rs1[i] = '0;
                    p_imm[i] = ($urandom % 256) * 4;
                end
                K_BR: begin
                    p_imm[i] = delta * 4;
                    p_f3[i]  = 3'(($urandom % 2) * 4 + ($urandom % 2));
                end
                K_LOAD, K_STORE: begin
                    p_rs1[i] = '0;
                    p_imm[i] = 32'h400 + ($urandom % 256) * 4;  // data words 256..511
                end
                K_IMM: begin
                    if (p_f3[i] == 3'b001 || p_f3[i] == 3'b101) begin
                        p_imm[i] = $urandom % 32;
                    end else begin
                        p_imm[i] = 32'($urandom_range(0, 4095)) - 32'd2048;
                    end
                end
                default: p_sub[i] = (p_f3[i] == 3'b000) && (($urandom % 2) == 1);
            endcase
            mem[i] = encode(i);
            mem[i + 256] = '0;
        end
    endtask

    // instruction-level model, fills the expected access and writeback lists
    task automatic run_model();
        logic [`XLEN-1:0] x [32];
        logic [`XLEN-1:0] dmem [512];
        logic [`XLEN-1:0] pc, a, b, ea, res, nxt;
        logic [2:0]       cls;
        logic             writes;
        int               w;
        for (int i = 0; i < 512; i++) begin
            dmem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = `RESET_PC;
        repeat (N_INSTR) begin
            w      = int'(pc[9:2]);
            a      = x[p_rs1[w]];
            b      = (p_kind[w] == K_REG) ? x[p_rs2[w]] : p_imm[w];
            ea     = a + p_imm[w];
            nxt    = pc + `PC_STEP;
            writes = 1'b1;
            cls    = 3'd2;
            exp_acc.push_back('{1'b0, pc, 32'h0, 3'd4});
            case (p_kind[w])
                K_LUI: res = p_imm[w];
                K_JAL, K_JALR: begin
                    res = pc + 4;
                    cls = 3'd4;
                    nxt = (p_kind[w] == K_JAL) ? pc + p_imm[w] : ea & ~32'd1;
                end
                K_BR: begin
                    writes = 1'b0;
                    if (branch_ref(p_f3[w], a, x[p_rs2[w]])) begin
                        nxt = pc + p_imm[w];
                    end
                end
                K_LOAD: begin
                    exp_acc.push_back('{1'b0, ea, 32'h0, 3'd3});
                    res = dmem[ea[10:2]];
                    cls = 3'd3;
                end
                K_STORE: begin
                    writes = 1'b0;
                    exp_acc.push_back('{1'b1, ea, x[p_rs2[w]], 3'd3});
                    dmem[ea[10:2]] = x[p_rs2[w]];
                end
                default: res = alu_ref(p_f3[w], p_sub[w], a, b);
            endcase
            if (writes && p_rd[w] != 5'd0) begin
                x[p_rd[w]] = res;
                exp_wb.push_back('{p_rd[w], res, cls});
            end
            pc = nxt;
        end
    endtask

    function automatic string test_name(int t);
        case (t)
            2:       return "alu and lui writebacks";
            3:       return "loads and stores";
            4:       return "fetch addresses and links";
            default: return "stalls and event count";
        endcase
    endfunction

    task automatic report_tests(output int n_fail);
        int n_assert;
        n_fail = (err[1] != 0) ? 1 : 0;
        for (int t = 2; t <= 5; t++) begin
            $display("test %0d %s: %s (%0d errors)", t, test_name(t),
                     (err[t] == 0) ? "PASS" : "FAIL", err[t]);
            if (err[t] != 0) begin
                n_fail++;
            end
        end
        n_assert = cpu_top_inst.cpu_asserts_inst.fail_count;
        $display("summary: %0d tests passed, %0d failed, %0d assertion failures, %0d stalls",
                 5 - n_fail, n_fail, n_assert, n_stall);
        n_fail += n_assert;
    endtask

    // all checks run on the rising edge, before the DUT registers update
    always @(posedge clk) begin
        cycles++;
        if (rst || !init_done) begin
            if (mem_o.rd || mem_o.wr || wb_o.en) begin
                $display("[ERROR] %0t: bus or writeback active during reset or init", $time);
                err[1]++;
            end
            init_done = !rst;
        end else if (!run_done) begin
            if (stalled && mem_o != held_req) begin
                $display("[ERROR] %0t: request changed while bus full", $time);
                err[5]++;
            end
            stalled  = (mem_o.rd || mem_o.wr) && bus_full_i;
            held_req = mem_o;
            if (stalled) begin
                n_stall++;
            end
            if ((mem_o.rd || mem_o.wr) && !bus_full_i) begin
                if (acc_idx == 0) begin
                    if (!mem_o.rd || mem_o.addr != `RESET_PC) begin
                        $display("[ERROR] %0t: first fetch at %h", $time, mem_o.addr);
                        err[1]++;
                    end
                    $display("test 1 reset and first fetch: %s (%0d errors)",
                             (err[1] == 0) ? "PASS" : "FAIL", err[1]);
                end
                if (acc_idx >= exp_acc.size()) begin
                    $display("bus access at %0t after the expected sequence ended", $time);
                    err[5]++;
                end else begin
                    acc_e = exp_acc[acc_idx];
                    if (mem_o.rd == acc_e.wr || mem_o.wr != acc_e.wr ||
                        mem_o.addr != acc_e.addr ||
                        (acc_e.wr && mem_o.wdata != acc_e.data)) begin
                        $display("[ERROR] %0t: access %0d rd=%0b wr=%0b %h %h, want wr=%0b %h %h",
                                 $time, acc_idx, mem_o.rd, mem_o.wr, mem_o.addr, mem_o.wdata,
                                 acc_e.wr, acc_e.addr, acc_e.data);
                        err[acc_e.cls]++;
                    end
                    acc_idx++;
                end
                if (mem_o.wr) begin
                    mem[mem_o.addr[10:2]] <= mem_o.wdata;
                end
            end
            if (wb_o.en) begin
                if (wb_o.rd == 5'd0) begin
                    $display("[ERROR] %0t: writeback to x0", $time);
                    err[2]++;
                end
                if (wb_idx >= exp_wb.size()) begin
                    $display("writeback at %0t after the expected sequence ended", $time);
                    err[5]++;
                end else begin
                    wb_e = exp_wb[wb_idx];
                    if (wb_o.rd != wb_e.rd || wb_o.data != wb_e.data) begin
                        $display("[ERROR] %0t: writeback %0d x%0d=%h, expected x%0d=%h",
                                 $time, wb_idx, wb_o.rd, wb_o.data, wb_e.rd, wb_e.data);
                        err[wb_e.cls]++;
                    end
                    wb_idx++;
                end
            end
            run_done = (acc_idx == exp_acc.size()) && (wb_idx == exp_wb.size());
        end
    end

    initial begin
        int n_fail;
        rst        = 1'b1;
        bus_full_i = 1'b0;
        stalled    = 1'b0;
        init_done  = 1'b0;
        run_done   = 1'b0;
        held_req   = '0;
        cycles     = 0;
        acc_idx    = 0;
        wb_idx     = 0;
        n_stall    = 0;
        for (int t = 1; t <= 5; t++) begin
            err[t] = 0;
        end
        void'($urandom(32'hc099));
        gen_program();
        run_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (!run_done && cycles <= MAX_CYCLES) begin
            @(negedge clk);
            bus_full_i = ($urandom % 4) == 0;
        end
        if (!run_done) begin
            $display("timeout: %0d instructions not retired within %0d cycles", N_INSTR,
                     MAX_CYCLES);
            $display("SOME TESTS FAILED");
        end else begin
            report_tests(n_fail);
            if (n_fail == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design/
design/rv_isa_pkg.sv
design/cpu_bus_pkg.sv
design/cycle_fsm.sv
design/program_counter.sv
design/instr_decoder.sv
design/alu_branch.sv
design/register_file.sv
design/bus_port.sv
design/cpu_top.sv
sim/cpu_asserts.sv
sim/tb_cpu.sv
